// ==== Bender.yml ====
package:
  name: md5_pipeline

export_include_dirs:
  - .

sources:
  - md5Pkg.sv
  - md5MessagePad.sv
  - md5Step.sv
  - md5Pipeline.sv
  - target: test
    files:
      - md5RefModel.sv
      - md5PipelineTb.sv

// ==== md5MessagePad.sv ====
`timescale 1ns/1ps
`include "md5_settings.svh"

module md5MessagePad (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic [127:0] guess,
	input logic [3:0] guessLength,
	output logic blockValid,
	output md5Pkg::md5LiveWords blockWords
);

	import md5Pkg::*;

	localparam int lengthSlot = liveSlot(14);

	md5LiveWords nextWords;

	// Byte i of the block lands in word i/4, little-endian within the word
	always_comb begin
		logic [7:0] padByte;
		nextWords = '0;
		for (int i = 0; i <= `MD5_MAX_GUESS_BYTES; i++) begin
			if (i < int'(guessLength))
				padByte = guess[127 - 8 * i -: 8];
			else if (i == int'(guessLength))
				padByte = 8'h80;
			else
				padByte = 8'h00;
			nextWords[i / 4][8 * (i % 4) +: 8] = padByte;
		end
		// Message length in bits, low word of the 64-bit length field
		nextWords[lengthSlot] = {25'd0, guessLength, 3'b000};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			blockValid <= 1'b0;
		end else begin
			blockValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			blockWords <= nextWords;
		end
	end

	// A sampled guess must carry a known length
	guessLengthKnown: assert property (
		@(posedge clk) disable iff (reset)
		inValid |-> !$isunknown(guessLength)
	);

endmodule

// ==== md5Pipeline.sv ====
`timescale 1ns/1ps
`include "md5_settings.svh"

module md5Pipeline (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic [127:0] guess,
	input logic [3:0] guessLength,
	output logic hashValid,
	output md5Pkg::md5Word hashA,
	output md5Pkg::md5Word hashB,
	output md5Pkg::md5Word hashC,
	output md5Pkg::md5Word hashD
);

	import md5Pkg::*;

	// Entry i feeds step i, entry MD5_STEPS is the last step's result
	md5Word stateA [0:`MD5_STEPS];
	md5Word stateB [0:`MD5_STEPS];
	md5Word stateC [0:`MD5_STEPS];
	md5Word stateD [0:`MD5_STEPS];
	md5LiveWords stepWords [0:`MD5_STEPS];
	logic stepValid [0:`MD5_STEPS];

	md5MessagePad uPad (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.guess(guess),
		.guessLength(guessLength),
		.blockValid(stepValid[0]),
		.blockWords(stepWords[0])
	);

	// Single block, so the chain starts from the standard values
	assign stateA[0] = `MD5_INIT_A;
	assign stateB[0] = `MD5_INIT_B;
	assign stateC[0] = `MD5_INIT_C;
	assign stateD[0] = `MD5_INIT_D;

	for (genvar i = 0; i < `MD5_STEPS; i++) begin : gStep
		md5Step #(
			.stepIndex(i)
		) uStep (
			.clk(clk),
			.reset(reset),
			.inValid(stepValid[i]),
			.a(stateA[i]),
			.b(stateB[i]),
			.c(stateC[i]),
			.d(stateD[i]),
			.inWords(stepWords[i]),
			.outValid(stepValid[i + 1]),
			.outA(stateA[i + 1]),
			.outB(stateB[i + 1]),
			.outC(stateC[i + 1]),
			.outD(stateD[i + 1]),
			.outWords(stepWords[i + 1])
		);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			hashValid <= 1'b0;
		end else begin
			hashValid <= stepValid[`MD5_STEPS];
		end
	end

	// Feed-forward of the chaining values
	always_ff @(posedge clk) begin
		hashA <= stateA[`MD5_STEPS] + `MD5_INIT_A;
		hashB <= stateB[`MD5_STEPS] + `MD5_INIT_B;
		hashC <= stateC[`MD5_STEPS] + `MD5_INIT_C;
		hashD <= stateD[`MD5_STEPS] + `MD5_INIT_D;
	end

endmodule

// ==== md5PipelineTb.sv ====
`timescale 1ns/1ps
`include "md5_settings.svh"

module md5PipelineTb;

	import md5RefModel::*;

	localparam int resetCycles = 16;
	localparam int idleCycles = 100;
	localparam int knownGuesses = 2;
	localparam int lengthGuesses = 16;
	localparam int burstGuesses = 200;
	localparam int gappedGuesses = 100;
	localparam int maxGap = 4;
	localparam int drainedTests = 5;
	localparam int pipeLatency = `MD5_STEPS + 2;
	localparam int timeoutLimit = resetCycles + idleCycles + knownGuesses + lengthGuesses + 1
		+ burstGuesses + gappedGuesses * (1 + maxGap) + drainedTests * (pipeLatency + 4) + 50;

	logic clk;
	logic reset;
	logic inValid;
	logic [127:0] guess;
	logic [3:0] guessLength;
	logic hashValid;
	logic [31:0] hashA;
	logic [31:0] hashB;
	logic [31:0] hashC;
	logic [31:0] hashD;

	logic [127:0] expectedQueue [$];
	logic [127:0] expectedDigest;
	logic [31:0] lfsrState = 32'h8e04;
	string currentTest = "reset";
	int cycleCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	int hashCount = 0;
	int currentRun = 0;
	int longestRun = 0;

	md5Pipeline UUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.guess(guess),
		.guessLength(guessLength),
		.hashValid(hashValid),
		.hashA(hashA),
		.hashB(hashB),
		.hashC(hashC),
		.hashD(hashD)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= timeoutLimit) begin
			$display("Timeout after %0d cycles in test %s, results still missing",
				cycleCount, currentTest);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic checkValue(string name, logic [127:0] expected, logic [127:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// Outputs are compared at the falling edge, away from register updates
	always @(negedge clk) begin
		if (!reset && hashValid) begin
			hashCount++;
			currentRun++;
			if (currentRun > longestRun)
				longestRun = currentRun;
			if (expectedQueue.size() == 0) begin
				errorCount++;
				$display("Unexpected hashValid pulse in test %s with no guess outstanding",
					currentTest);
			end else begin
				expectedDigest = expectedQueue.pop_front();
				checkValue(currentTest, expectedDigest, digestBytes(hashA, hashB, hashC, hashD));
			end
		end else begin
			currentRun = 0;
		end
	end

	function automatic logic [127:0] randomBits(int count);
		logic [127:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = galoisStep(lfsrState);
			value = {value[126:0], lfsrState[0]};
		end
		return value;
	endfunction

	// Called 1 ns after a rising edge, returns at the same point one cycle later
	task automatic driveGuess(logic [127:0] value, logic [3:0] length);
		guess = value;
		guessLength = length;
		inValid = 1'b1;
		expectedQueue.push_back(md5Digest(value, int'(length)));
		@(posedge clk);
		#1;
		inValid = 1'b0;
	endtask

	task automatic waitDrain();
		while (expectedQueue.size() != 0)
			@(negedge clk);
		@(posedge clk);
		#1;
	endtask

	task automatic finishTest(int errorsBefore);
		$display("Test %s finished with %0d errors", currentTest, errorCount - errorsBefore);
	endtask

	task automatic idleAfterReset();
		int errorsBefore;
		errorsBefore = errorCount;
		currentTest = "idle";
		for (int i = 0; i < idleCycles; i++) begin
			@(negedge clk);
			checkValue(currentTest, 128'(1'b0), 128'(hashValid));
		end
		@(posedge clk);
		#1;
		finishTest(errorsBefore);
	endtask

	task automatic knownStrings();
		int errorsBefore;
		logic [127:0] abcGuess;
		errorsBefore = errorCount;
		abcGuess = {24'h616263, 104'h0};
		currentTest = "knownModel";
		checkValue(currentTest, 128'hd41d8cd98f00b204e9800998ecf8427e, md5Digest(128'h0, 0));
		checkValue(currentTest, 128'h900150983cd24fb0d6963f7d28e17f72, md5Digest(abcGuess, 3));
		currentTest = "knownStrings";
		driveGuess(128'h0, 4'd0);
		driveGuess(abcGuess, 4'd3);
		waitDrain();
		finishTest(errorsBefore);
	endtask

	task automatic allLengths();
		int errorsBefore;
		int countBefore;
		errorsBefore = errorCount;
		countBefore = hashCount;
		currentTest = "allLengths";
		for (int len = 0; len <= `MD5_MAX_GUESS_BYTES; len++)
			driveGuess(randomBits(128), 4'(len));
		waitDrain();
		checkValue(currentTest, 128'(lengthGuesses), 128'(hashCount - countBefore));
		finishTest(errorsBefore);
	endtask

	task automatic singleGuessLatency();
		int errorsBefore;
		int countBefore;
		int sampledAt;
		errorsBefore = errorCount;
		countBefore = hashCount;
		currentTest = "latency";
		// The guess is presented during this cycle and taken at its closing edge
		sampledAt = cycleCount;
		driveGuess(randomBits(128), 4'(randomBits(4)));
		do
			@(negedge clk);
		while (!hashValid);
		checkValue(currentTest, 128'(pipeLatency), 128'(cycleCount - sampledAt));
		waitDrain();
		checkValue(currentTest, 128'(1), 128'(hashCount - countBefore));
		finishTest(errorsBefore);
	endtask

	task automatic backToBackBurst();
		int errorsBefore;
		int countBefore;
		errorsBefore = errorCount;
		countBefore = hashCount;
		currentTest = "backToBack";
		longestRun = 0;
		for (int i = 0; i < burstGuesses; i++)
			driveGuess(randomBits(128), 4'(randomBits(4)));
		waitDrain();
		checkValue(currentTest, 128'(burstGuesses), 128'(hashCount - countBefore));
		// All results must come out as one unbroken run
		checkValue(currentTest, 128'(burstGuesses), 128'(longestRun));
		finishTest(errorsBefore);
	endtask

	task automatic gappedStream();
		int errorsBefore;
		int countBefore;
		int gap;
		errorsBefore = errorCount;
		countBefore = hashCount;
		currentTest = "gapped";
		for (int i = 0; i < gappedGuesses; i++) begin
			driveGuess(randomBits(128), 4'(randomBits(4)));
			gap = 1 + int'(randomBits(2));
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
		end
		waitDrain();
		checkValue(currentTest, 128'(gappedGuesses), 128'(hashCount - countBefore));
		finishTest(errorsBefore);
	endtask

	initial begin
		reset = 1'b1;
		inValid = 1'b0;
		guess = '0;
		guessLength = '0;
		repeat (resetCycles) @(posedge clk);
		#1;
		reset = 1'b0;

		idleAfterReset();
		knownStrings();
		allLengths();
		singleGuessLatency();
		backToBackBurst();
		gappedStream();

		$display("Done: %0d checks, %0d errors, %0d hashes, %0d cycles",
			checkCount, errorCount, hashCount, cycleCount);
		if (errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== md5Pkg.sv ====
`include "md5_settings.svh"

package md5Pkg;

	typedef logic [`MD5_WORD_BITS-1:0] md5Word;

	// Slots 0 to 3 hold message words 0 to 3, slot 4 holds word 14
	typedef md5Word [`MD5_LIVE_WORDS-1:0] md5LiveWords;

	typedef enum logic [1:0] {
		roundF,
		roundG,
		roundH,
		roundI
	} roundFunction;

	// Slot code for message words that are always zero
	localparam int zeroSlot = `MD5_LIVE_WORDS;

	localparam int rotateTable [4][4] = '{
		'{7, 12, 17, 22},
		'{5, 9, 14, 20},
		'{4, 11, 16, 23},
		'{6, 10, 15, 21}
	};

	// Integer part of abs(sin(i + 1)) * 2^32
	localparam md5Word constantTable [`MD5_STEPS] = '{
		32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
		32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
		32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
		32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
		32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
		32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
		32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
		32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
		32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
		32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
		32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
		32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
		32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
		32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
		32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
		32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
	};

	function automatic roundFunction stepRound(int step);
		case (step / 16)
			0: return roundF;
			1: return roundG;
			2: return roundH;
			default: return roundI;
		endcase
	endfunction

	function automatic int stepRotate(int step);
		return rotateTable[step / 16][step % 4];
	endfunction

	function automatic md5Word stepConstant(int step);
		return constantTable[step];
	endfunction

	// Message schedule of the four rounds
	function automatic int stepWordIndex(int step);
		case (step / 16)
			0: return step % 16;
			1: return (5 * step + 1) % 16;
			2: return (3 * step + 5) % 16;
			default: return (7 * step) % 16;
		endcase
	endfunction

	function automatic int liveSlot(int wordIndex);
		if (wordIndex >= 0 && wordIndex <= 3)
			return wordIndex;
		else if (wordIndex == 14)
			return 4;
		else
			return zeroSlot;
	endfunction

endpackage

// ==== md5RefModel.sv ====
`include "md5_settings.svh"

package md5RefModel;

	// One step of a 32-bit Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] galoisStep(logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h80200003;
		else
			return state >> 1;
	endfunction

	// Integer part of abs(sin(i + 1)) * 2^32
	function automatic logic [31:0] sineConstant(int i);
		real value;
		value = $sin(real'(i + 1));
		if (value < 0.0)
			value = -value;
		return 32'(longint'($floor(value * 4294967296.0)));
	endfunction

	function automatic int shiftAmount(int i);
		int row [4];
		case (i / 16)
			0: row = '{7, 12, 17, 22};
			1: row = '{5, 9, 14, 20};
			2: row = '{4, 11, 16, 23};
			default: row = '{6, 10, 15, 21};
		endcase
		return row[i % 4];
	endfunction

	function automatic logic [31:0] rotateLeft(logic [31:0] x, int s);
		return (x << s) | (x >> (32 - s));
	endfunction

	// Digest words to the usual byte-order hex form
	function automatic logic [127:0] digestBytes(logic [31:0] a, logic [31:0] b,
			logic [31:0] c, logic [31:0] d);
		logic [31:0] words [4];
		logic [127:0] result;
		words = '{a, b, c, d};
		for (int w = 0; w < 4; w++)
			for (int k = 0; k < 4; k++)
				result[127 - 8 * (4 * w + k) -: 8] = words[w][8 * k +: 8];
		return result;
	endfunction

	// Full 64-byte padding and the 64-step compression of one block
	function automatic logic [127:0] md5Digest(logic [127:0] guess, int length);
		logic [7:0] block [64];
		logic [31:0] m [16];
		logic [63:0] bitLength;
		logic [31:0] a, b, c, d, f, temp;
		int g;
		for (int i = 0; i < 64; i++)
			block[i] = 8'h00;
		for (int i = 0; i < length; i++)
			block[i] = guess[127 - 8 * i -: 8];
		block[length] = 8'h80;
		bitLength = 64'(length) * 8;
		for (int i = 0; i < 8; i++)
			block[56 + i] = bitLength[8 * i +: 8];
		for (int j = 0; j < 16; j++)
			m[j] = {block[4 * j + 3], block[4 * j + 2], block[4 * j + 1], block[4 * j]};
		a = `MD5_INIT_A;
		b = `MD5_INIT_B;
		c = `MD5_INIT_C;
		d = `MD5_INIT_D;
		for (int i = 0; i < 64; i++) begin
			case (i / 16)
				0: begin
					f = (b & c) | (~b & d);
					g = i;
				end
				1: begin
					f = (d & b) | (~d & c);
					g = (5 * i + 1) % 16;
				end
				2: begin
					f = b ^ c ^ d;
					g = (3 * i + 5) % 16;
				end
				default: begin
					f = c ^ (b | ~d);
					g = (7 * i) % 16;
				end
			endcase
			temp = d;
			d = c;
			c = b;
			b = b + rotateLeft(a + f + sineConstant(i) + m[g], shiftAmount(i));
			a = temp;
		end
		return digestBytes(a + `MD5_INIT_A, b + `MD5_INIT_B, c + `MD5_INIT_C, d + `MD5_INIT_D);
	endfunction

endpackage

// ==== md5Step.sv ====
`timescale 1ns/1ps
`include "md5_settings.svh"

module md5Step #(
	parameter int stepIndex = 0
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input md5Pkg::md5Word a,
	input md5Pkg::md5Word b,
	input md5Pkg::md5Word c,
	input md5Pkg::md5Word d,
	input md5Pkg::md5LiveWords inWords,
	output logic outValid,
	output md5Pkg::md5Word outA,
	output md5Pkg::md5Word outB,
	output md5Pkg::md5Word outC,
	output md5Pkg::md5Word outD,
	output md5Pkg::md5LiveWords outWords
);

	import md5Pkg::*;

	localparam roundFunction roundKind = stepRound(stepIndex);
	localparam int rotateAmount = stepRotate(stepIndex);
	localparam md5Word addConstant = stepConstant(stepIndex);
	localparam int wordSlot = liveSlot(stepWordIndex(stepIndex));

	md5Word roundValue;
	md5Word messageWord;
	md5Word stepSum;
	md5Word rotated;

	always_comb begin
		case (roundKind)
			roundF: roundValue = (b & c) | (~b & d);
			roundG: roundValue = (b & d) | (c & ~d);
			roundH: roundValue = b ^ c ^ d;
			default: roundValue = c ^ (b | ~d);
		endcase
	end

	// Words 4 to 13 and 15 are known zero and never travel down the pipe
	if (wordSlot == zeroSlot) begin : gZeroWord
		assign messageWord = '0;
	end else begin : gLiveWord
		assign messageWord = inWords[wordSlot];
	end

	assign stepSum = a + roundValue + messageWord + addConstant;
	assign rotated = (stepSum << rotateAmount) | (stepSum >> (`MD5_WORD_BITS - rotateAmount));

	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
		end else begin
			outValid <= inValid;
		end
	end

	// Standard role shift: new A is old D, new B is the mixed word
	always_ff @(posedge clk) begin
		outA <= d;
		outB <= b + rotated;
		outC <= b;
		outD <= c;
		outWords <= inWords;
	end

	validKnown: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(outValid)
	);

endmodule

// ==== md5_settings.svh ====
`ifndef MD5_SETTINGS_SVH
`define MD5_SETTINGS_SVH

// Pipeline depth, one stage per MD5 step
`define MD5_STEPS 64

`define MD5_WORD_BITS 32

// Message words 0 to 3 and 14, the only ones a short guess can fill
`define MD5_LIVE_WORDS 5

// Guess, 0x80 marker and length must fit in one block
`define MD5_MAX_GUESS_BYTES 15

// Standard initial chaining values
`define MD5_INIT_A 32'h67452301
`define MD5_INIT_B 32'hefcdab89
`define MD5_INIT_C 32'h98badcfe
`define MD5_INIT_D 32'h10325476

`endif

// ==== verilog.f ====
+incdir+.
md5Pkg.sv
md5MessagePad.sv
md5Step.sv
md5Pipeline.sv
md5RefModel.sv
md5PipelineTb.sv
